// ==== hw/defines.sv ====
// shared widths, RV32I encodings and instruction views, referenced by scoped name from every block
package defines;

	// datapath width is fixed for RV32I
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;

	// all-zero word, also the x0 value
	localparam data_t NULL = '0;

	// register index, x0 to x31
	typedef logic [4:0] reg_addr_t;

	// major opcodes seen by the front end
	typedef enum logic [6:0] {
		B      = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		LUI    = 7'b0110111
	} opcode_t;

	// branch conditions, funct3 of the B format
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} funct3_t;

	// where a decode operand comes from
	typedef enum logic [1:0] {
		RS_ID_SEL  = 2'b00,
		EX_ID_SEL  = 2'b01,
		MEM_ID_SEL = 2'b10,
		WB_ID_SEL  = 2'b11
	} id_fwd_sel_t;

	// one instruction word, two decodes
	// fld is the R/I/S/B field split, jmp splits the J immediate bits
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			funct3_t    funct3;
			reg_addr_t  rd;
			opcode_t    opcode;
		} fld;
		struct packed {
			logic       imm_sign;
			logic [9:0] imm_lo10;
			logic       imm_11;
			logic [7:0] imm_hi8;
			reg_addr_t  rd;
			opcode_t    opcode;
		} jmp;
	} instr_t;

endpackage : defines

// ==== hw/fetch_if.sv ====
// fetch to decode link; carries the IF/ID word forward and the redirect back to the pc
`timescale 1ns/10ps

interface fetch_if;

	// IF/ID contents
	defines::data_t  pc;
	defines::instr_t instr;
	logic            valid;

	// decode resolved a taken transfer this cycle
	logic            redirect;
	defines::data_t  target;

	modport fetch (output pc, output instr, output valid, input redirect, input target);

	// mirror side, used by the decode stage
	modport decode (input pc, input instr, input valid, output redirect, output target);

endinterface : fetch_if

// ==== hw/pc_fetch.sv ====
// fetch stage; drives the instruction memory address and loads the IF/ID register each cycle
`timescale 1ns/10ps

module pc_fetch #(
	parameter defines::data_t RESET_PC = 32'h0000_0000
) (
	input  logic           clk,
	input  logic           rst_n,
	output defines::data_t imem_addr,
	input  defines::data_t imem_rdata,
	fetch_if.fetch         fe
);

	defines::data_t pc;

	// memory answers in the same cycle
	assign imem_addr = pc;

	// pc and the IF/ID valid bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= RESET_PC;
			fe.valid <= 1'b0;
		end else begin
			// word fetched alongside a taken transfer is wrong path, drop it
			fe.valid <= !fe.redirect;
			if (fe.redirect) begin
				pc <= fe.target;
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

	// IF/ID payload, qualified by fe.valid
	always_ff @(posedge clk) begin
		fe.pc    <= pc;
		fe.instr <= defines::instr_t'(imem_rdata);
	end

	// target is built in decode, bit 0 must be cleared there for every transfer kind
	a_target_aligned : assert property (
		@(posedge clk) disable iff (!rst_n)
		fe.redirect |-> (fe.target[0] == 1'b0)
	);

endmodule : pc_fetch

// ==== hw/reg_file.sv ====
// integer register file; two combinational decode reads and one WB write port
`timescale 1ns/10ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  defines::reg_addr_t rs1_addr,
	input  defines::reg_addr_t rs2_addr,
	output defines::data_t     rs1,
	output defines::data_t     rs2,
	input  logic               we,
	input  defines::reg_addr_t rd,
	input  defines::data_t     wd
);

	defines::data_t regs [32];

	// write on WB, x0 stays zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= defines::NULL;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wd;
		end
	end

	// no write-through here
	// a same-cycle WB hit is picked up by the WB forward select instead
	always_comb begin
		if (rs1_addr == 5'd0) begin
			rs1 = defines::NULL;
		end else begin
			rs1 = regs[rs1_addr];
		end
		if (rs2_addr == 5'd0) begin
			rs2 = defines::NULL;
		end else begin
			rs2 = regs[rs2_addr];
		end
	end

endmodule : reg_file

// ==== hw/id_fwd_ctrl.sv ====
// decode forward control; picks the newest in-flight producer for each source register
`timescale 1ns/10ps

module id_fwd_ctrl (
	input  defines::reg_addr_t   rs1_addr,
	input  defines::reg_addr_t   rs2_addr,
	input  defines::reg_addr_t   ex_rd,
	input  defines::reg_addr_t   mem_rd,
	input  defines::reg_addr_t   wb_rd,
	input  logic                 ex_we,
	input  logic                 mem_we,
	input  logic                 wb_we,
	output defines::id_fwd_sel_t fwd_rs1,
	output defines::id_fwd_sel_t fwd_rs2
);

	// stage hits, x0 never matches
	logic ex_hit1, mem_hit1, wb_hit1;
	logic ex_hit2, mem_hit2, wb_hit2;

	always_comb begin
		ex_hit1  = ex_we  && (ex_rd  != 5'd0) && (ex_rd  == rs1_addr);
		mem_hit1 = mem_we && (mem_rd != 5'd0) && (mem_rd == rs1_addr);
		wb_hit1  = wb_we  && (wb_rd  != 5'd0) && (wb_rd  == rs1_addr);
		ex_hit2  = ex_we  && (ex_rd  != 5'd0) && (ex_rd  == rs2_addr);
		mem_hit2 = mem_we && (mem_rd != 5'd0) && (mem_rd == rs2_addr);
		wb_hit2  = wb_we  && (wb_rd  != 5'd0) && (wb_rd  == rs2_addr);
	end

	// youngest producer wins, EX then MEM then WB
	always_comb begin
		fwd_rs1 = ex_hit1  ? defines::EX_ID_SEL  :
		          mem_hit1 ? defines::MEM_ID_SEL :
		          wb_hit1  ? defines::WB_ID_SEL  :
		          defines::RS_ID_SEL;
		fwd_rs2 = ex_hit2  ? defines::EX_ID_SEL  :
		          mem_hit2 ? defines::MEM_ID_SEL :
		          wb_hit2  ? defines::WB_ID_SEL  :
		          defines::RS_ID_SEL;
	end

	// x0 must come from the register file so it reads zero
	always_comb begin
		a_x0_from_rf : assert final (
			((rs1_addr != 5'd0) || (fwd_rs1 == defines::RS_ID_SEL)) &&
			((rs2_addr != 5'd0) || (fwd_rs2 == defines::RS_ID_SEL))
		);
	end

endmodule : id_fwd_ctrl

// ==== hw/pc_adder.sv ====
// decode branch resolver; forwards operands, evaluates the condition and builds the transfer target
`timescale 1ns/10ps

module pc_adder (
	input  defines::instr_t      instr,
	input  defines::data_t       pc,
	input  defines::data_t       rs1,
	input  defines::data_t       rs2,
	input  defines::data_t       ex_data,
	input  defines::data_t       mem_data,
	input  defines::data_t       wb_data,
	input  defines::id_fwd_sel_t fwd_rs1,
	input  defines::id_fwd_sel_t fwd_rs2,
	output defines::data_t       pc_bj,
	output defines::data_t       pc_nxt,
	output logic                 pc_sel,
	output logic                 branch_taken,
	output defines::data_t       op1,
	output defines::data_t       op2
);

	defines::opcode_t opcode;
	defines::funct3_t funct3;

	// condition flags on the forwarded operands
	logic beq_take, bne_take, blt_take, bge_take, bltu_take, bgeu_take;
	logic cond_hit;

	// immediates and adder results
	defines::data_t imm_b, imm_j, imm_i, imm;
	defines::data_t pc_add_imm, op1_add_imm;

	assign opcode = instr.fld.opcode;
	assign funct3 = instr.fld.funct3;

	// operand forward mux
	always_comb begin
		case (fwd_rs1)
			defines::EX_ID_SEL:  op1 = ex_data;
			defines::MEM_ID_SEL: op1 = mem_data;
			defines::WB_ID_SEL:  op1 = wb_data;
			default:             op1 = rs1;
		endcase
		case (fwd_rs2)
			defines::EX_ID_SEL:  op2 = ex_data;
			defines::MEM_ID_SEL: op2 = mem_data;
			defines::WB_ID_SEL:  op2 = wb_data;
			default:             op2 = rs2;
		endcase
	end

	always_comb begin
		beq_take  = (op1 == op2);
		bne_take  = (op1 != op2);
		blt_take  = ($signed(op1) < $signed(op2));
		bge_take  = ($signed(op1) >= $signed(op2));
		bltu_take = (op1 < op2);
		bgeu_take = (op1 >= op2);
	end

	// funct3 picks one flag, undefined funct3 never takes
	always_comb begin
		case (funct3)
			defines::BEQ:  cond_hit = beq_take;
			defines::BNE:  cond_hit = bne_take;
			defines::BLT:  cond_hit = blt_take;
			defines::BGE:  cond_hit = bge_take;
			defines::BLTU: cond_hit = bltu_take;
			defines::BGEU: cond_hit = bgeu_take;
			default:       cond_hit = 1'b0;
		endcase
		branch_taken = cond_hit && (opcode == defines::B);
	end

	// B and J offsets are in halfwords, I is in bytes
	always_comb begin
		imm_b = {{20{instr.fld.funct7[6]}}, instr.fld.rd[0], instr.fld.funct7[5:0],
		         instr.fld.rd[4:1], 1'b0};
		imm_j = {{12{instr.jmp.imm_sign}}, instr.jmp.imm_hi8, instr.jmp.imm_11,
		         instr.jmp.imm_lo10, 1'b0};
		imm_i = {{20{instr.fld.funct7[6]}}, instr.fld.funct7, instr.fld.rs2};
		case (opcode)
			defines::B:    imm = imm_b;
			defines::JAL:  imm = imm_j;
			defines::JALR: imm = imm_i;
			default:       imm = defines::NULL;
		endcase
	end

	// pc relative for B and JAL, register relative for JALR
	always_comb begin
		pc_add_imm  = pc + imm;
		op1_add_imm = op1 + imm;
		if (opcode == defines::JALR) begin
			// JALR drops the low bit of the sum
			pc_bj = {op1_add_imm[31:1], 1'b0};
		end else begin
			pc_bj = pc_add_imm;
		end
		pc_sel = branch_taken || (opcode == defines::JAL) || (opcode == defines::JALR);
		pc_nxt = pc_sel ? pc_bj : (pc + 32'd4);
	end

endmodule : pc_adder

// ==== hw/id_issue.sv ====
// ID/EX register; sends the redirect back to fetch and hands the decoded word to execute
`timescale 1ns/10ps

module id_issue (
	input  logic            clk,
	input  logic            rst_n,
	fetch_if.decode         de,
	input  logic            pc_sel,
	input  logic            branch_taken,
	input  defines::data_t  pc_bj,
	input  defines::data_t  op1,
	input  defines::data_t  op2,
	output logic            issue_valid,
	output defines::data_t  issue_pc,
	output defines::instr_t issue_instr,
	output defines::data_t  issue_op_a,
	output defines::data_t  issue_op_b,
	output defines::data_t  issue_link,
	output logic            issue_taken
);

	// only a live decode word may steer fetch
	assign de.redirect = de.valid && pc_sel;
	assign de.target   = pc_bj;

	// control bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
			issue_taken <= 1'b0;
		end else begin
			issue_valid <= de.valid;
			issue_taken <= de.redirect;
		end
	end

	// payload, meaningful only with issue_valid
	always_ff @(posedge clk) begin
		issue_pc    <= de.pc;
		issue_instr <= de.instr;
		issue_op_a  <= op1;
		issue_op_b  <= op2;
		// return address for JAL and JALR
		issue_link  <= de.pc + 32'd4;
	end

	// nothing leaves decode in the first cycle out of reset
	a_no_issue_after_rst : assert property (
		@(posedge clk) !rst_n |=> !issue_valid
	);

	// a taken branch is always a redirect and always a B opcode
	a_taken_is_branch : assert property (
		@(posedge clk) disable iff (!rst_n)
		branch_taken |-> (pc_sel && (de.instr.fld.opcode == defines::B))
	);

endmodule : id_issue

// ==== hw/branch_id_top.sv ====
// fetch and decode front end top; wires fetch, register file, forwarding, resolver and issue
`timescale 1ns/10ps

module branch_id_top #(
	parameter defines::data_t RESET_PC = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst_n,
	output defines::data_t     imem_addr,
	input  defines::data_t     imem_rdata,
	input  defines::data_t     ex_data,
	input  defines::data_t     mem_data,
	input  defines::data_t     wb_data,
	input  defines::reg_addr_t ex_rd,
	input  defines::reg_addr_t mem_rd,
	input  defines::reg_addr_t wb_rd,
	input  logic               ex_we,
	input  logic               mem_we,
	input  logic               wb_we,
	output logic               issue_valid,
	output defines::data_t     issue_pc,
	output defines::instr_t    issue_instr,
	output defines::data_t     issue_op_a,
	output defines::data_t     issue_op_b,
	output defines::data_t     issue_link,
	output logic               issue_taken
);

	// decode stage nets
	defines::data_t       rs1, rs2;
	defines::id_fwd_sel_t fwd_rs1, fwd_rs2;
	defines::data_t       pc_bj, op1, op2;
	logic                 pc_sel, branch_taken;

	fetch_if fe_bus ();

	pc_fetch #(
		.RESET_PC (RESET_PC)
	) fetch0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.fe         (fe_bus.fetch)
	);

	// WB writes here as well as forwarding
	reg_file rf0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (fe_bus.instr.fld.rs1),
		.rs2_addr (fe_bus.instr.fld.rs2),
		.rs1      (rs1),
		.rs2      (rs2),
		.we       (wb_we),
		.rd       (wb_rd),
		.wd       (wb_data)
	);

	id_fwd_ctrl fwd0 (
		.rs1_addr (fe_bus.instr.fld.rs1),
		.rs2_addr (fe_bus.instr.fld.rs2),
		.ex_rd    (ex_rd),
		.mem_rd   (mem_rd),
		.wb_rd    (wb_rd),
		.ex_we    (ex_we),
		.mem_we   (mem_we),
		.wb_we    (wb_we),
		.fwd_rs1  (fwd_rs1),
		.fwd_rs2  (fwd_rs2)
	);

	// pc_nxt is left open, fetch advances on its own and takes pc_bj on a redirect
	pc_adder bj0 (
		.instr        (fe_bus.instr),
		.pc           (fe_bus.pc),
		.rs1          (rs1),
		.rs2          (rs2),
		.ex_data      (ex_data),
		.mem_data     (mem_data),
		.wb_data      (wb_data),
		.fwd_rs1      (fwd_rs1),
		.fwd_rs2      (fwd_rs2),
		.pc_bj        (pc_bj),
		.pc_nxt       (),
		.pc_sel       (pc_sel),
		.branch_taken (branch_taken),
		.op1          (op1),
		.op2          (op2)
	);

	id_issue issue0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.de           (fe_bus.decode),
		.pc_sel       (pc_sel),
		.branch_taken (branch_taken),
		.pc_bj        (pc_bj),
		.op1          (op1),
		.op2          (op2),
		.issue_valid  (issue_valid),
		.issue_pc     (issue_pc),
		.issue_instr  (issue_instr),
		.issue_op_a   (issue_op_a),
		.issue_op_b   (issue_op_b),
		.issue_link   (issue_link),
		.issue_taken  (issue_taken)
	);

endmodule : branch_id_top

// ==== sim/tb_branch_id.sv ====
// testbench for the fetch and decode front end; runs a generated program against a reference model
`timescale 1ns/10ps

module tb_branch_id;

	localparam defines::data_t RESET_PC = 32'h0000_0100;
	// program words, the last two are plain ALU ops
	localparam int PROG_LEN = 48;
	localparam defines::data_t END_PC = RESET_PC + 32'(4 * (PROG_LEN - 1));
	localparam int CYCLE_LIMIT = 2 * PROG_LEN + 50;

	// EX, MEM and WB results as seen in one decode cycle
	typedef struct packed {
		defines::data_t     ex_data, mem_data, wb_data;
		defines::reg_addr_t ex_rd, mem_rd, wb_rd;
		logic               ex_we, mem_we, wb_we;
	} stage_t;

	typedef struct packed {
		defines::data_t op_a, op_b, link, next_pc;
		logic           taken;
	} expect_t;

	typedef defines::data_t rf_t [32];

	logic clk;
	logic rst_n;
	defines::data_t imem_addr, imem_rdata;
	defines::data_t ex_data, mem_data, wb_data;
	defines::reg_addr_t ex_rd, mem_rd, wb_rd;
	logic ex_we, mem_we, wb_we;
	logic issue_valid, issue_taken;
	defines::data_t issue_pc, issue_op_a, issue_op_b, issue_link;
	defines::instr_t issue_instr;

	integer seed = 32'h05c1_095f;
	defines::data_t prog [PROG_LEN];
	logic prog_ready = 1'b0;
	// mirror of the register file, and the decode-cycle copy of it
	rf_t mirror, snap_rf;
	stage_t snap_st;
	defines::data_t exp_pc = RESET_PC;
	logic last_taken = 1'b0;
	logic done = 1'b0;
	int post_rst = 0;
	int cycles = 0;
	int data_errs = 0;
	int instr_errs = 0;
	int flag_errs = 0;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	branch_id_top #(
		.RESET_PC (RESET_PC)
	) dut0 (
		.clk (clk), .rst_n (rst_n), .imem_addr (imem_addr), .imem_rdata (imem_rdata),
		.ex_data (ex_data), .mem_data (mem_data), .wb_data (wb_data),
		.ex_rd (ex_rd), .mem_rd (mem_rd), .wb_rd (wb_rd),
		.ex_we (ex_we), .mem_we (mem_we), .wb_we (wb_we),
		.issue_valid (issue_valid), .issue_pc (issue_pc), .issue_instr (issue_instr),
		.issue_op_a (issue_op_a), .issue_op_b (issue_op_b), .issue_link (issue_link),
		.issue_taken (issue_taken)
	);

	// outside the program every word is a harmless ALU op built from the address
	function automatic defines::data_t fill_word(defines::data_t a);
		logic [11:0] mix;
		mix = a[31:20] ^ a[19:8] ^ {a[7:0], 4'h0};
		return {mix, a[6:2], 3'b000, a[11:7], defines::OP_IMM};
	endfunction

	function automatic defines::data_t image_word(defines::data_t a);
		int idx;
		idx = int'((a - RESET_PC) >> 2);
		if ((a[1:0] == 2'b00) && (a >= RESET_PC) && (a < RESET_PC + 32'(4 * PROG_LEN))) begin
			return prog[idx];
		end
		return fill_word(a);
	endfunction

	// memory answers combinationally
	assign imem_rdata = prog_ready ? image_word(imem_addr) : defines::NULL;

	function automatic defines::data_t encode_i(defines::opcode_t op, defines::reg_addr_t rd,
			logic [2:0] f3, defines::reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic defines::data_t encode_b(defines::funct3_t f3, defines::reg_addr_t rs1,
			defines::reg_addr_t rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], defines::B};
	endfunction

	function automatic defines::data_t encode_j(defines::reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, defines::JAL};
	endfunction

	function automatic defines::funct3_t branch_f3(int n);
		case (n % 6)
			0: return defines::BEQ;
			1: return defines::BNE;
			2: return defines::BLT;
			3: return defines::BGE;
			4: return defines::BLTU;
			default: return defines::BGEU;
		endcase
	endfunction

	// all transfers go forward by two words so the run always reaches END_PC
	task automatic build_program();
		logic [31:0] r;
		defines::data_t pc;
		int kind;
		int n_br;
		n_br = 0;
		for (int i = 0; i < PROG_LEN; i++) begin
			r = $random(seed);
			pc = RESET_PC + 32'(4 * i);
			kind = (i >= PROG_LEN - 2) ? 0 : (i % 8);
			case (kind)
				1, 3, 5: begin
					prog[i] = encode_b(branch_f3(n_br), {2'b00, r[2:0]}, {2'b00, r[5:3]}, 13'd8);
					n_br++;
				end
				2: prog[i] = encode_i(defines::OP_IMM, {2'b00, r[2:0]}, 3'b000, {2'b00, r[5:3]},
						r[17:6]);
				4: prog[i] = encode_j({2'b00, r[2:0]}, 21'd8);
				// base x0, odd immediate on some of them to exercise the bit 0 clear
				6: prog[i] = encode_i(defines::JALR, {2'b00, r[2:0]}, 3'b000, 5'd0,
						pc[11:0] + 12'd8 + {11'd0, r[20]});
				7: prog[i] = encode_i(r[6] ? defines::LOAD : defines::LUI, {2'b00, r[2:0]},
						3'b010, {2'b00, r[5:3]}, r[19:8]);
				default: prog[i] = {7'd0, 2'b00, r[5:3], 2'b00, r[8:6], 3'b000, 2'b00, r[2:0],
						defines::OP};
			endcase
		end
	endtask

	// small values make equal and signed/unsigned-split operands common
	function automatic defines::data_t random_operand();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		case (r[1:0])
			2'b00: return {30'd0, s[1:0]};
			2'b01: return {{30{1'b1}}, s[1:0]};
			default: return s;
		endcase
	endfunction

	task automatic drive_stages();
		logic [31:0] r;
		r = $random(seed);
		ex_data  = random_operand();
		mem_data = random_operand();
		wb_data  = random_operand();
		// program uses x0..x7 so forwarding hits are frequent
		ex_rd  = {2'b00, r[2:0]};
		mem_rd = {2'b00, r[5:3]};
		wb_rd  = {2'b00, r[8:6]};
		ex_we  = r[9];
		mem_we = r[10];
		wb_we  = r[11];
	endtask

	function automatic defines::data_t pick_operand(defines::reg_addr_t r, stage_t st, rf_t rf);
		if (r == 5'd0) return defines::NULL;
		if (st.ex_we && (st.ex_rd == r)) return st.ex_data;
		if (st.mem_we && (st.mem_rd == r)) return st.mem_data;
		if (st.wb_we && (st.wb_rd == r)) return st.wb_data;
		return rf[r];
	endfunction

	// expected issue results from the RV32I rules
	function automatic expect_t predict(defines::data_t w, defines::data_t pc, stage_t st, rf_t rf);
		expect_t e;
		defines::data_t imm_b, imm_j, imm_i, target;
		e.op_a = pick_operand(w[19:15], st, rf);
		e.op_b = pick_operand(w[24:20], st, rf);
		e.link = pc + 32'd4;
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		imm_i = {{20{w[31]}}, w[31:20]};
		e.taken = 1'b0;
		target = pc + 32'd4;
		case (w[6:0])
			defines::B: begin
				target = pc + imm_b;
				case (w[14:12])
					defines::BEQ:  e.taken = (e.op_a == e.op_b);
					defines::BNE:  e.taken = (e.op_a != e.op_b);
					defines::BLT:  e.taken = ($signed(e.op_a) < $signed(e.op_b));
					defines::BGE:  e.taken = ($signed(e.op_a) >= $signed(e.op_b));
					defines::BLTU: e.taken = (e.op_a < e.op_b);
					defines::BGEU: e.taken = (e.op_a >= e.op_b);
					default:       e.taken = 1'b0;
				endcase
			end
			defines::JAL: begin
				target = pc + imm_j;
				e.taken = 1'b1;
			end
			defines::JALR: begin
				target = (e.op_a + imm_i) & ~32'd1;
				e.taken = 1'b1;
			end
			default: e.taken = 1'b0;
		endcase
		e.next_pc = e.taken ? target : (pc + 32'd4);
		return e;
	endfunction

	task automatic check_data(input string what, input defines::data_t got,
			input defines::data_t want);
		if (got !== want) begin
			data_errs++;
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_instr(input defines::instr_t got, input defines::instr_t want);
		if (got !== want) begin
			instr_errs++;
			$display("ERROR %0t: issue_instr is %h, expected %h", $time, got, want);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		if (got !== want) begin
			flag_errs++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	initial begin : stimulus
		rst_n = 1'b0;
		ex_data = defines::NULL;
		mem_data = defines::NULL;
		wb_data = defines::NULL;
		ex_rd = 5'd0;
		mem_rd = 5'd0;
		wb_rd = 5'd0;
		ex_we = 1'b0;
		mem_we = 1'b0;
		wb_we = 1'b0;
		for (int i = 0; i < 32; i++) begin
			mirror[i] = defines::NULL;
		end
		build_program();
		prog_ready = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		drive_stages();
		forever begin
			@(posedge clk);
			#1;
			drive_stages();
		end
	end

	// outputs are sampled mid-cycle, one cycle after the decode they came from
	always @(negedge clk) begin : compare
		expect_t want;
		logic exp_valid;
		if (!rst_n) begin
			check_bit("issue_valid in reset", issue_valid, 1'b0);
		end else begin
			// two-cycle fill, then one bubble only after a taken transfer
			exp_valid = (post_rst >= 2) && !last_taken;
			check_bit("issue_valid", issue_valid, exp_valid);
			if (exp_valid && (issue_valid === 1'b1)) begin
				want = predict(image_word(exp_pc), exp_pc, snap_st, snap_rf);
				check_data("issue_pc", issue_pc, exp_pc);
				check_instr(issue_instr, defines::instr_t'(image_word(exp_pc)));
				check_data("issue_op_a", issue_op_a, want.op_a);
				check_data("issue_op_b", issue_op_b, want.op_b);
				check_data("issue_link", issue_link, want.link);
				check_bit("issue_taken", issue_taken, want.taken);
				last_taken = want.taken;
				if (exp_pc == END_PC) begin
					done = 1'b1;
				end
				exp_pc = want.next_pc;
			end else begin
				last_taken = 1'b0;
			end
			post_rst++;
			// inputs seen by the instruction now in decode
			snap_st.ex_data = ex_data;
			snap_st.mem_data = mem_data;
			snap_st.wb_data = wb_data;
			snap_st.ex_rd = ex_rd;
			snap_st.mem_rd = mem_rd;
			snap_st.wb_rd = wb_rd;
			snap_st.ex_we = ex_we;
			snap_st.mem_we = mem_we;
			snap_st.wb_we = wb_we;
			snap_rf = mirror;
			// this cycle's WB lands at the next edge
			if (wb_we && (wb_rd != 5'd0)) begin
				mirror[wb_rd] = wb_data;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the last program word was not issued within %0d cycles",
				CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin : report
		wait (done);
		#1;
		$display("error counts: data %0d, instr %0d, flag %0d", data_errs, instr_errs, flag_errs);
		if ((data_errs + instr_errs + flag_errs) == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule : tb_branch_id

// ==== filelist.f ====
hw/defines.sv
hw/fetch_if.sv
hw/pc_fetch.sv
hw/reg_file.sv
hw/id_fwd_ctrl.sv
hw/pc_adder.sv
hw/id_issue.sv
hw/branch_id_top.sv
sim/tb_branch_id.sv

// ==== Makefile ====
# Verilator build and run for the fetch and decode front end

VERILATOR ?= verilator
TOP       ?= tb_branch_id
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
